// ==== tb.f ====
+incdir+src
src/umi_pkg.sv
src/umi_cmd_decode.sv
src/umi_endpoint.sv
src/umi_regfile.sv
src/umi_reg_subsys.sv
test/umi_reg_subsys_sva.sv
test/umi_reg_subsys_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the UMI register subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f tb.f --top-module umi_reg_subsys_tb -o sim_tb

if ./obj_dir/sim_tb +verilator+error+limit+100 | tee /dev/stderr \
      | grep "Test completed successfully" > /dev/null
then
   echo "Simulation passed"
else
   echo "Simulation did not pass"
   exit 1
fi

// ==== test/umi_reg_subsys_tb.sv ====
/*
 * UMI register subsystem testbench
 * Directed tests against a reference model of the register bank
 */

`timescale 1ns/1ps
`default_nettype none

`include "umi_config.svh"

module umi_reg_subsys_tb;

   localparam int TMO = 50;   // Cycles per wait

   logic                  clk;
   logic                  nreset;
   logic                  req_valid;
   umi_pkg::umi_packet_t  req;
   logic                  req_ready;
   logic                  resp_valid;
   umi_pkg::umi_packet_t  resp;
   logic                  resp_ready;

   logic [`UMI_DW-1:0]    model [`UMI_NREGS];   // Expected register contents
   logic [31:0]           lcg_state;
   int                    errors;
   int                    checks;
   int                    tests;

   umi_reg_subsys UUT
   (
      .clk        (clk),
      .nreset     (nreset),
      .req_valid  (req_valid),
      .req        (req),
      .req_ready  (req_ready),
      .resp_valid (resp_valid),
      .resp       (resp),
      .resp_ready (resp_ready)
   );

   always #5 clk = ~clk;

   // ######################################
   // Models and helpers
   // ######################################
   function automatic logic [`UMI_DW-1:0] rand64();
      logic [31:0] hi;
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      hi = lcg_state;
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return {hi, lcg_state};
   endfunction

   // UMI atomic semantics on the old value
   function automatic logic [`UMI_DW-1:0] atomic_result(input logic [7:0] atype,
         input logic [`UMI_DW-1:0] old, input logic [`UMI_DW-1:0] op);
      logic signed [`UMI_DW-1:0] s_old;
      logic signed [`UMI_DW-1:0] s_op;
      s_old = old;
      s_op = op;
      case (atype)
         umi_pkg::AT_ADD:  return old + op;
         umi_pkg::AT_AND:  return old & op;
         umi_pkg::AT_OR:   return old | op;
         umi_pkg::AT_XOR:  return old ^ op;
         umi_pkg::AT_MAX:  return (s_op > s_old) ? op : old;
         umi_pkg::AT_MIN:  return (s_op < s_old) ? op : old;
         umi_pkg::AT_MAXU: return (op > old) ? op : old;
         umi_pkg::AT_MINU: return (op < old) ? op : old;
         default:          return op;
      endcase
   endfunction

   function automatic umi_pkg::umi_packet_t make_req(input logic [4:0] opcode,
         input logic [7:0] atype, input logic [3:0] idx, input logic [`UMI_DW-1:0] data);
      umi_pkg::umi_packet_t p;
      logic [`UMI_DW-1:0]   r;
      r = rand64();
      p.cmd = r[31:0];   // Random hostid, qos and friends
      p.cmd.opcode = opcode;
      p.cmd.len_atype = atype;
      p.dstaddr = {r[63:32], 32'h0};
      p.dstaddr[`UMI_REG_LSB +: 4] = idx;
      p.srcaddr = rand64();
      p.data = data;
      return p;
   endfunction

   function automatic umi_pkg::umi_packet_t expect_resp(input umi_pkg::umi_packet_t r,
         input logic [4:0] opcode, input logic [`UMI_DW-1:0] data);
      umi_pkg::umi_packet_t e;
      e = r;
      e.cmd.opcode = opcode;
      e.dstaddr = r.srcaddr;   // Addresses swap
      e.srcaddr = r.dstaddr;
      e.data = data;
      return e;
   endfunction

   // ######################################
   // Compare tasks
   // ######################################
   task automatic check_data(input string name, input logic [`UMI_DW-1:0] got,
         input logic [`UMI_DW-1:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Fail at %0d ns: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_cmd(input string name, input umi_pkg::umi_cmd_t got,
         input umi_pkg::umi_cmd_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Fail at %0d ns: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_pkt(input string name, input umi_pkg::umi_packet_t got,
         input umi_pkg::umi_packet_t exp);
      check_cmd({name, ".cmd"}, got.cmd, exp.cmd);
      check_data({name, ".dstaddr"}, got.dstaddr, exp.dstaddr);
      check_data({name, ".srcaddr"}, got.srcaddr, exp.srcaddr);
      check_data({name, ".data"}, got.data, exp.data);
   endtask

   task automatic report_timeout(input string what);
      errors++;
      $display("Timeout after %0d cycles waiting for %s at %0d ns", TMO, what, $time);
   endtask

   // ######################################
   // Bus tasks, entered 1 ns after an edge
   // ######################################
   task automatic send_req(input umi_pkg::umi_packet_t pkt);
      int n;
      n = 0;
      req = pkt;
      req_valid = 1'b1;
      @(negedge clk);
      while (!req_ready && n < TMO)
      begin
         @(negedge clk);
         n++;
      end
      if (!req_ready)
         report_timeout("req_ready");
      @(posedge clk);
      #1;
      req_valid = 1'b0;
   endtask

   task automatic recv_resp(output umi_pkg::umi_packet_t pkt);
      int n;
      n = 0;
      @(negedge clk);
      while (!(resp_valid && resp_ready) && n < TMO)
      begin
         @(negedge clk);
         n++;
      end
      if (!(resp_valid && resp_ready))
         report_timeout("resp_valid");
      pkt = resp;
      @(posedge clk);
      #1;
   endtask

   task automatic expect_silence(input int ncyc);
      for (int n = 0; n < ncyc; n++)
      begin
         @(negedge clk);
         if (resp_valid)
         begin
            errors++;
            $display("Unexpected response seen at %0d ns", $time);
         end
      end
      @(posedge clk);
      #1;
   endtask

   // One request, model update and response check
   task automatic access(input logic [4:0] opcode, input logic [7:0] atype,
         input logic [3:0] idx, input logic [`UMI_DW-1:0] data);
      umi_pkg::umi_packet_t r;
      umi_pkg::umi_packet_t got;
      logic [`UMI_DW-1:0]   old;
      logic [4:0]           rsp_op;
      r = make_req(opcode, atype, idx, data);
      old = model[idx];
      rsp_op = (opcode == umi_pkg::OP_REQ_WRITE) ? umi_pkg::OP_RESP_WRITE : umi_pkg::OP_RESP_READ;
      send_req(r);
      if (opcode == umi_pkg::OP_REQ_WRITE || opcode == umi_pkg::OP_REQ_POSTED)
         model[idx] = data;
      else if (opcode == umi_pkg::OP_REQ_ATOMIC)
         model[idx] = atomic_result(atype, old, data);
      if (opcode == umi_pkg::OP_REQ_READ || opcode == umi_pkg::OP_REQ_WRITE ||
          opcode == umi_pkg::OP_REQ_ATOMIC)
      begin
         recv_resp(got);
         check_pkt("resp", got, expect_resp(r, rsp_op, old));   // Old value comes back
      end
      else
         expect_silence(8);
   endtask

   task automatic read_all();
      for (int i = 0; i < `UMI_NREGS; i++)
         access(umi_pkg::OP_REQ_READ, 8'd0, 4'(i), '0);
   endtask

   // ######################################
   // Tests
   // ######################################
   task automatic test_reset();
      int n;
      n = 0;
      check_data("resp_valid", {63'd0, resp_valid}, '0);
      @(negedge clk);
      check_data("req_ready", {63'd0, req_ready}, '0);   // Synchronizer still filling
      while (!req_ready && n < TMO)
      begin
         @(negedge clk);
         n++;
      end
      if (!req_ready)
         report_timeout("req_ready after reset");
      @(posedge clk);
      #1;
      read_all();
   endtask

   task automatic test_write_read();
      access(umi_pkg::OP_REQ_WRITE, 8'd0, 4'd5, rand64());
      access(umi_pkg::OP_REQ_READ, 8'd0, 4'd5, '0);
      access(umi_pkg::OP_REQ_WRITE, 8'd0, 4'd15, rand64());
      access(umi_pkg::OP_REQ_READ, 8'd0, 4'd15, '0);
   endtask

   task automatic test_posted();
      access(umi_pkg::OP_REQ_POSTED, 8'd0, 4'd6, rand64());
      access(umi_pkg::OP_REQ_READ, 8'd0, 4'd6, '0);
   endtask

   task automatic test_atomics();
      access(umi_pkg::OP_REQ_WRITE, 8'd0, 4'd10, rand64());
      for (int t = 0; t < 9; t++)
      begin
         access(umi_pkg::OP_REQ_ATOMIC, 8'(t), 4'd10, rand64());
         access(umi_pkg::OP_REQ_READ, 8'd0, 4'd10, '0);
      end
   endtask

   task automatic test_backpressure();
      umi_pkg::umi_packet_t rd;
      umi_pkg::umi_packet_t wr;
      umi_pkg::umi_packet_t got;
      logic [`UMI_DW-1:0]   wval;
      wval = rand64();
      rd = make_req(umi_pkg::OP_REQ_READ, 8'd0, 4'd5, '0);
      wr = make_req(umi_pkg::OP_REQ_WRITE, 8'd0, 4'd6, wval);
      resp_ready = 1'b0;
      send_req(rd);
      fork
         send_req(wr);   // Waits behind the stalled response
         begin
            for (int i = 0; i < 6; i++)
            begin
               @(negedge clk);
               check_data("resp_valid", {63'd0, resp_valid}, 64'd1);
               check_pkt("held resp", resp, expect_resp(rd, umi_pkg::OP_RESP_READ, model[5]));
               check_data("req_ready", {63'd0, req_ready}, '0);
               check_data("loc strobes",
                          {61'd0, UUT.loc.read, UUT.loc.write, UUT.loc.atomic}, '0);
            end
            @(posedge clk);
            #1;
            resp_ready = 1'b1;
            recv_resp(got);
            check_pkt("resp 1", got, expect_resp(rd, umi_pkg::OP_RESP_READ, model[5]));
            recv_resp(got);
            check_pkt("resp 2", got, expect_resp(wr, umi_pkg::OP_RESP_WRITE, model[6]));
            model[6] = wval;
         end
      join
      access(umi_pkg::OP_REQ_READ, 8'd0, 4'd6, '0);
   endtask

   task automatic test_invalid();
      access(5'd0, 8'd0, 4'd5, rand64());
      access(umi_pkg::OP_RESP_READ, 8'd0, 4'd6, rand64());
      read_all();
   endtask

   task automatic finish_test(input string name, input int errs_before);
      tests++;
      $display("%-14s done, %0d errors", name, errors - errs_before);
   endtask

   initial
   begin
      int e;
      clk = 1'b0;
      nreset = 1'b0;
      req_valid = 1'b0;
      req = '0;
      resp_ready = 1'b1;
      lcg_state = 32'd41;
      errors = 0;
      checks = 0;
      tests = 0;
      for (int i = 0; i < `UMI_NREGS; i++)
         model[i] = '0;
      repeat (5) @(posedge clk);
      #1;
      nreset = 1'b1;

      e = errors;
      test_reset();
      finish_test("reset", e);
      e = errors;
      test_write_read();
      finish_test("write_read", e);
      e = errors;
      test_posted();
      finish_test("posted", e);
      e = errors;
      test_atomics();
      finish_test("atomics", e);
      e = errors;
      test_backpressure();
      finish_test("backpressure", e);
      e = errors;
      test_invalid();
      finish_test("invalid", e);

      if (UUT.u_endpoint.u_sva.err_count != 0)
      begin
         errors += UUT.u_endpoint.u_sva.err_count;
         $display("%0d assertion failures in the endpoint", UUT.u_endpoint.u_sva.err_count);
      end
      $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/umi_reg_subsys_sva.sv ====
/*
 * UMI endpoint protocol assertions
 * Bound into every endpoint instance
 */

`timescale 1ns/1ps
`default_nettype none

module umi_reg_subsys_sva
(
   input logic                  clk,
   input logic                  nreset,
   input logic                  req_valid,
   input umi_pkg::umi_packet_t  req,
   input logic                  req_ready,
   input logic                  resp_valid,
   input umi_pkg::umi_packet_t  resp,
   input logic                  resp_ready,
   input umi_pkg::loc_req_t     loc
);

   int         err_count = 0;   // Failed assertions so far
   logic       accepted;
   logic       supported;
   logic       strobe_match;
   logic [2:0] strobes;

   assign accepted  = req_valid & req_ready;
   assign strobes   = {loc.read, loc.write, loc.atomic};
   assign supported = (req.cmd.opcode == umi_pkg::OP_REQ_READ)
                    | (req.cmd.opcode == umi_pkg::OP_REQ_WRITE)
                    | (req.cmd.opcode == umi_pkg::OP_REQ_POSTED)
                    | (req.cmd.opcode == umi_pkg::OP_REQ_ATOMIC);

   // Strobe kind against the request opcode
   assign strobe_match =
        (loc.read   && (req.cmd.opcode == umi_pkg::OP_REQ_READ))
      | (loc.write  && ((req.cmd.opcode == umi_pkg::OP_REQ_WRITE) ||
                        (req.cmd.opcode == umi_pkg::OP_REQ_POSTED)))
      | (loc.atomic && (req.cmd.opcode == umi_pkg::OP_REQ_ATOMIC));

   a_reset_quiet: assert property (@(posedge clk) !nreset |-> !resp_valid)
      else
      begin
         err_count++;
         $error("resp_valid high during reset");
      end

   a_resp_hold: assert property (@(posedge clk) disable iff (!nreset)
      resp_valid && !resp_ready |=> resp_valid && $stable(resp))
      else
      begin
         err_count++;
         $error("stalled response changed or dropped");
      end

   // One access per supported request, none for the rest
   a_one_strobe: assert property (@(posedge clk) disable iff (!nreset)
      accepted |-> (supported ? $onehot(strobes) : (strobes == 3'b000)))
      else
      begin
         err_count++;
         $error("wrong number of local strobes for an accepted request");
      end

   a_strobe_accept: assert property (@(posedge clk) disable iff (!nreset)
      (strobes != 3'b000) |-> (accepted && strobe_match))
      else
      begin
         err_count++;
         $error("local strobe without a matching accepted request");
      end

endmodule

bind umi_endpoint umi_reg_subsys_sva u_sva
(
   .clk        (clk),
   .nreset     (nreset),
   .req_valid  (req_valid),
   .req        (req),
   .req_ready  (req_ready),
   .resp_valid (resp_valid),
   .resp       (resp),
   .resp_ready (resp_ready),
   .loc        (loc)
);

`default_nettype wire

// ==== src/umi_reg_subsys.sv ====
/*
 * UMI register subsystem
 * Endpoint in front of the register bank
 */

`timescale 1ns/1ps
`default_nettype none

`include "umi_config.svh"

module umi_reg_subsys #(
   parameter int REG = `UMI_RESP_REG
)
(
   input  logic                  clk,
   input  logic                  nreset,
   // Request channel
   input  logic                  req_valid,
   input  umi_pkg::umi_packet_t  req,
   output logic                  req_ready,
   // Response channel
   output logic                  resp_valid,
   output umi_pkg::umi_packet_t  resp,
   input  logic                  resp_ready
);

   umi_pkg::loc_req_t    loc;
   logic [`UMI_DW-1:0]   loc_rddata;
   logic                 loc_ready;

   umi_endpoint #(.REG(REG)) u_endpoint
   (
      .clk        (clk),
      .nreset     (nreset),
      .req_valid  (req_valid),
      .req        (req),
      .req_ready  (req_ready),
      .resp_valid (resp_valid),
      .resp       (resp),
      .resp_ready (resp_ready),
      .loc        (loc),
      .loc_rddata (loc_rddata),
      .loc_ready  (loc_ready)
   );

   umi_regfile u_regfile
   (
      .clk    (clk),
      .nreset (nreset),
      .loc    (loc),
      .rddata (loc_rddata),
      .ready  (loc_ready)
   );

endmodule

`default_nettype wire

// ==== src/umi_regfile.sv ====
/*
 * UMI register bank
 * 64-bit registers with registered read data, writes and
 * read-modify-write atomics
 */

`timescale 1ns/1ps
`default_nettype none

`include "umi_config.svh"

module umi_regfile
(
   input  logic                clk,
   input  logic                nreset,
   input  umi_pkg::loc_req_t   loc,
   output logic [`UMI_DW-1:0]  rddata,
   output logic                ready
);

   localparam int IDXW = $clog2(`UMI_NREGS);

   logic [`UMI_DW-1:0]  regs [`UMI_NREGS];
   logic [IDXW-1:0]     idx;
   logic                access;
   logic                atom_pend;
   logic [IDXW-1:0]     atom_idx;
   logic [7:0]          atom_type;
   logic [`UMI_DW-1:0]  atom_op;
   logic [`UMI_DW-1:0]  atom_res;

   assign idx    = loc.addr[`UMI_REG_LSB +: IDXW];
   assign access = loc.read | loc.write | loc.atomic;
   assign ready  = ~atom_pend;   // Busy for the writeback cycle

   // Old value of any accessed register
   always_ff @(posedge clk)
   begin
      if (access)
         rddata <= regs[idx];
   end

   // ######################################
   // Atomic writeback
   // ######################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         atom_pend <= 1'b0;
      else
         atom_pend <= loc.atomic;
   end

   always_ff @(posedge clk)
   begin
      if (loc.atomic)
      begin
         atom_idx  <= idx;
         atom_type <= loc.atype;
         atom_op   <= loc.wrdata;
      end
   end

   // rddata still holds the old value here
   always_comb
   begin
      case (atom_type)
         umi_pkg::AT_ADD:  atom_res = rddata + atom_op;
         umi_pkg::AT_AND:  atom_res = rddata & atom_op;
         umi_pkg::AT_OR:   atom_res = rddata | atom_op;
         umi_pkg::AT_XOR:  atom_res = rddata ^ atom_op;
         umi_pkg::AT_MAX:  atom_res = ($signed(rddata) > $signed(atom_op)) ? rddata : atom_op;
         umi_pkg::AT_MIN:  atom_res = ($signed(rddata) < $signed(atom_op)) ? rddata : atom_op;
         umi_pkg::AT_MAXU: atom_res = (rddata > atom_op) ? rddata : atom_op;
         umi_pkg::AT_MINU: atom_res = (rddata < atom_op) ? rddata : atom_op;
         umi_pkg::AT_SWAP: atom_res = atom_op;
         default:          atom_res = rddata;   // Unknown type leaves it alone
      endcase
   end

   // ######################################
   // Register array
   // ######################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         for (int i = 0; i < `UMI_NREGS; i++)
            regs[i] <= '0;
      end
      else if (atom_pend)
         regs[atom_idx] <= atom_res;
      else if (loc.write)
         regs[idx] <= loc.wrdata;   // Posted or acknowledged
   end

endmodule

`default_nettype wire

// ==== src/umi_endpoint.sv ====
/*
 * UMI device-port endpoint
 * Turns single-beat UMI requests into local register strobes
 * and returns one response beat, held under back-pressure
 */

`timescale 1ns/1ps
`default_nettype none

`include "umi_config.svh"

module umi_endpoint #(
   parameter int REG = `UMI_RESP_REG   // 1 registers the response path
)
(
   input  logic                  clk,
   input  logic                  nreset,
   // Device port
   input  logic                  req_valid,
   input  umi_pkg::umi_packet_t  req,
   output logic                  req_ready,
   output logic                  resp_valid,
   output umi_pkg::umi_packet_t  resp,
   input  logic                  resp_ready,
   // Local register port
   output umi_pkg::loc_req_t     loc,
   input  logic [`UMI_DW-1:0]    loc_rddata,
   input  logic                  loc_ready
);

   logic [1:0]               rst_sync;
   logic                     ready_gated;
   umi_pkg::umi_cmd_class_t  cls;
   umi_pkg::umi_cmd_t        resp_cmd;
   logic                     accept;
   logic                     loc_resp;
   logic                     request_stall;
   logic                     loc_resp_vld;
   logic                     loc_vld_keep;
   logic                     loc_vld_out;
   umi_pkg::umi_cmd_t        hdr_cmd;
   logic [`UMI_AW-1:0]       hdr_dstaddr;
   logic [`UMI_AW-1:0]       hdr_srcaddr;
   logic [`UMI_DW-1:0]       data_keep;
   umi_pkg::umi_packet_t     resp_int;

   umi_cmd_decode u_decode
   (
      .cmd      (req.cmd),
      .cls      (cls),
      .resp_cmd (resp_cmd)
   );

   // ######################################
   // Request side
   // ######################################

   // Ready stays low until reset has left the synchronizer
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         rst_sync <= 2'b00;
      else
         rst_sync <= {rst_sync[0], 1'b1};
   end

   assign ready_gated = rst_sync[1];
   assign req_ready   = ready_gated & loc_ready & ~request_stall;
   assign accept      = req_valid & req_ready;

   assign loc.addr   = req.dstaddr;
   assign loc.wrdata = req.data;
   assign loc.atype  = req.cmd.len_atype;
   assign loc.read   = accept & cls.read;
   assign loc.write  = accept & (cls.write | cls.posted);
   assign loc.atomic = accept & cls.atomic;

   // Posted and invalid requests are consumed silently
   assign loc_resp = accept & (cls.read | cls.write | cls.atomic);

   // ######################################
   // Response capture
   // ######################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         loc_resp_vld <= 1'b0;
      else
         loc_resp_vld <= loc_resp;
   end

   // Header is known at acceptance, addresses swap
   always_ff @(posedge clk)
   begin
      if (loc_resp)
      begin
         hdr_cmd     <= resp_cmd;
         hdr_dstaddr <= req.srcaddr;
         hdr_srcaddr <= req.dstaddr;
      end
   end

   // Read data only lives for one cycle
   always_ff @(posedge clk)
   begin
      if (loc_resp_vld)
         data_keep <= loc_rddata;
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         loc_vld_keep <= 1'b0;
      else if (loc_resp_vld && !resp_ready)
         loc_vld_keep <= 1'b1;   // Stalled, hold on
      else if (resp_ready)
         loc_vld_keep <= 1'b0;
   end

   assign loc_vld_out      = loc_resp_vld | loc_vld_keep;
   assign resp_int.cmd     = hdr_cmd;
   assign resp_int.dstaddr = hdr_dstaddr;
   assign resp_int.srcaddr = hdr_srcaddr;
   assign resp_int.data    = loc_resp_vld ? loc_rddata : data_keep;

   // ######################################
   // Output stage
   // ######################################
   if (REG != 0)
   begin : g_out_reg
      logic                  vld_pipe;
      umi_pkg::umi_packet_t  pkt_pipe;

      always_ff @(posedge clk or negedge nreset)
      begin
         if (!nreset)
            vld_pipe <= 1'b0;
         else if (resp_ready)
            vld_pipe <= loc_vld_out;
      end

      always_ff @(posedge clk)
      begin
         if (resp_ready)
            pkt_pipe <= resp_int;
      end

      assign resp_valid    = vld_pipe;
      assign resp          = pkt_pipe;
      assign request_stall = (vld_pipe | loc_vld_out) & ~resp_ready;   // Two in flight
   end
   else
   begin : g_out_comb
      assign resp_valid    = loc_vld_out;
      assign resp          = resp_int;
      assign request_stall = loc_vld_out & ~resp_ready;
   end

endmodule

`default_nettype wire

// ==== src/umi_cmd_decode.sv ====
/*
 * UMI command decoder
 * Classifies a request command and forms the matching response command
 */

`timescale 1ns/1ps
`default_nettype none

module umi_cmd_decode
(
   input  umi_pkg::umi_cmd_t       cmd,
   output umi_pkg::umi_cmd_class_t cls,
   output umi_pkg::umi_cmd_t       resp_cmd
);

   // Request classes
   always_comb
   begin
      cls = '0;
      case (cmd.opcode)
         umi_pkg::OP_REQ_READ:
            cls.read = 1'b1;
         umi_pkg::OP_REQ_WRITE:
            cls.write = 1'b1;
         umi_pkg::OP_REQ_POSTED:
            cls.posted = 1'b1;
         umi_pkg::OP_REQ_ATOMIC:
            cls.atomic = 1'b1;
         default:
            cls.invalid = 1'b1;   // Responses, link, user, rdma and reserved
      endcase
   end

   // Response command keeps every field except the opcode
   always_comb
   begin
      resp_cmd = cmd;
      if (cls.read || cls.atomic)
      begin
         resp_cmd.opcode = umi_pkg::OP_RESP_READ;   // Atomics return the old value
      end
      else
      begin
         resp_cmd.opcode = umi_pkg::OP_RESP_WRITE;
      end
   end

endmodule

`default_nettype wire

// ==== src/umi_pkg.sv ====
/*
 * UMI package
 * Opcode and atomic-type constants, packet and local access structs
 */

`default_nettype none

`include "umi_config.svh"

package umi_pkg;

   // ######################################
   // Opcodes
   // ######################################
   localparam logic [4:0] OP_REQ_READ   = 5'd1;
   localparam logic [4:0] OP_RESP_READ  = 5'd2;
   localparam logic [4:0] OP_REQ_WRITE  = 5'd3;
   localparam logic [4:0] OP_RESP_WRITE = 5'd4;
   localparam logic [4:0] OP_REQ_POSTED = 5'd5;
   localparam logic [4:0] OP_REQ_ATOMIC = 5'd9;

   // Atomic types, carried in the len field
   localparam logic [7:0] AT_ADD  = 8'd0;
   localparam logic [7:0] AT_AND  = 8'd1;
   localparam logic [7:0] AT_OR   = 8'd2;
   localparam logic [7:0] AT_XOR  = 8'd3;
   localparam logic [7:0] AT_MAX  = 8'd4;
   localparam logic [7:0] AT_MIN  = 8'd5;
   localparam logic [7:0] AT_MAXU = 8'd6;
   localparam logic [7:0] AT_MINU = 8'd7;
   localparam logic [7:0] AT_SWAP = 8'd8;

   // ######################################
   // Types
   // ######################################
   typedef struct packed {
      logic [4:0] hostid;
      logic [1:0] user;
      logic       ex;
      logic       eof;
      logic       eom;
      logic [1:0] prot;
      logic [3:0] qos;
      logic [7:0] len_atype;   // Length, or atomic type
      logic [2:0] size;
      logic [4:0] opcode;
   } umi_cmd_t;

   typedef struct packed {
      umi_cmd_t              cmd;
      logic [`UMI_AW-1:0]    dstaddr;
      logic [`UMI_AW-1:0]    srcaddr;
      logic [`UMI_DW-1:0]    data;
   } umi_packet_t;

   // One-hot request class
   typedef struct packed {
      logic read;
      logic write;     // Acknowledged write
      logic posted;
      logic atomic;
      logic invalid;
   } umi_cmd_class_t;

   typedef struct packed {
      logic [`UMI_AW-1:0]    addr;
      logic                  read;
      logic                  write;
      logic                  atomic;
      logic [7:0]            atype;
      logic [`UMI_DW-1:0]    wrdata;
   } loc_req_t;

endpackage

`default_nettype wire

// ==== src/umi_config.svh ====
/*
 * UMI register endpoint configuration
 * Bus widths, register bank size and the response stage default
 */

`ifndef UMI_CONFIG_SVH
`define UMI_CONFIG_SVH

// Bus widths
`define UMI_AW 64        // Address width
`define UMI_DW 64        // Data width
`define UMI_CW 32        // Command width

// Register bank
`define UMI_NREGS   16   // Number of 64-bit registers
`define UMI_REG_LSB 3    // First address bit of the register index

// Endpoint output stage
`define UMI_RESP_REG 0   // 1 adds a register on the response path

`endif
